//--- hw/csr_access_arbiter.sv
`timescale 1ns/1ps

// Fixed priority on the CSR file bus with commit first
module csr_access_arbiter
    import drac_pkg::*;
    import csr_pkg::*;
(
    input  logic                     cmt_ena_i,
    input  csr_cmd_t                 cmt_cmd_i,
    input  logic [CSR_ADDR_SIZE-1:0] cmt_addr_i,
    input  logic [XLEN-1:0]          cmt_wdata_i,
    input  logic                     cmt_xcpt_i,
    input  logic [CAUSE_WIDTH-1:0]   cmt_cause_i,
    input  logic [PC_WIDTH-1:0]      cmt_pc_i,
    input  logic                     cmt_retire_i,
    input  logic                     dbg_pend_i,
    input  csr_cmd_t                 dbg_cmd_i,
    input  logic [CSR_ADDR_SIZE-1:0] dbg_addr_i,
    input  logic [XLEN-1:0]          dbg_wdata_i,
    output csr_cmd_t                 rf_cmd_o,
    output logic [CSR_ADDR_SIZE-1:0] rf_addr_o,
    output logic [XLEN-1:0]          rf_wdata_o,
    output logic                     rf_xcpt_o,
    output logic [CAUSE_WIDTH-1:0]   rf_cause_o,
    output logic [PC_WIDTH-1:0]      rf_pc_o,
    output logic                     rf_retire_o,
    output logic                     dbg_gnt_o
);

    logic cmt_own;

    // Any commit activity keeps the bus including a bare retire
    assign cmt_own = cmt_ena_i || cmt_xcpt_i || cmt_retire_i;

    always_comb begin
        rf_cmd_o   = CSR_CMD_NOPE;
        rf_addr_o  = '0;
        rf_wdata_o = '0;
        dbg_gnt_o  = 1'b0;
        if (cmt_own) begin
            rf_cmd_o   = cmt_cmd_i;
            rf_addr_o  = cmt_addr_i;
            rf_wdata_o = cmt_wdata_i;
        end else if (dbg_pend_i) begin
            rf_cmd_o   = dbg_cmd_i;
            rf_addr_o  = dbg_addr_i;
            rf_wdata_o = dbg_wdata_i;
            dbg_gnt_o  = 1'b1;
        end
        // Commit command without enable would lose the bus to debug
        if (!cmt_ena_i) begin
            assert (cmt_cmd_i == CSR_CMD_NOPE)
                else $error("csr_access_arbiter: commit command without enable");
        end
    end

    // Side channels go through regardless of owner
    assign rf_xcpt_o   = cmt_xcpt_i;
    assign rf_cause_o  = cmt_cause_i;
    assign rf_pc_o     = cmt_pc_i;
    assign rf_retire_o = cmt_retire_i;

endmodule

//--- hw/csr_debug_port.sv
`timescale 1ns/1ps

// Host side CSR access, one request in flight
module csr_debug_port
    import drac_pkg::*;
    import csr_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     dbg_req_i,     // One-cycle strobe
    input  csr_cmd_t                 dbg_cmd_i,
    input  logic [CSR_ADDR_SIZE-1:0] dbg_addr_i,
    input  logic [XLEN-1:0]          dbg_wdata_i,
    input  logic                     dbg_gnt_i,     // Bus is ours this cycle
    input  logic [XLEN-1:0]          rf_rdata_i,
    output logic                     dbg_pend_o,
    output csr_cmd_t                 dbg_cmd_o,
    output logic [CSR_ADDR_SIZE-1:0] dbg_addr_o,
    output logic [XLEN-1:0]          dbg_wdata_o,
    output logic                     dbg_busy_o,
    output logic                     dbg_done_o,
    output logic [XLEN-1:0]          dbg_rdata_o    // Value before the write
);

    typedef enum logic {IDLE, PENDING} dbg_state_t;

    dbg_state_t               state_q, state_d;
    csr_cmd_t                 cmd_q;
    logic [CSR_ADDR_SIZE-1:0] addr_q;
    logic [XLEN-1:0]          wdata_q;
    logic [XLEN-1:0]          rdata_q;
    logic                     done_q;
    logic                     take_req;

    assign take_req = dbg_req_i && (state_q == IDLE);  // Strobe while busy is dropped

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (take_req && !dbg_gnt_i) state_d = PENDING; // Commit holds the bus
            PENDING: if (dbg_gnt_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= dbg_gnt_i;   // Done one cycle after grant
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_req) begin
            cmd_q   <= dbg_cmd_i;
            addr_q  <= dbg_addr_i;
            wdata_q <= dbg_wdata_i;
        end
        if (dbg_gnt_i) rdata_q <= rf_rdata_i;  // Old value, write lands at this edge
    end

    // Fresh strobe bypasses the latch so an idle bus answers in one cycle
    assign dbg_pend_o  = take_req || (state_q == PENDING);
    assign dbg_cmd_o   = take_req ? dbg_cmd_i : cmd_q;
    assign dbg_addr_o  = take_req ? dbg_addr_i : addr_q;
    assign dbg_wdata_o = take_req ? dbg_wdata_i : wdata_q;
    assign dbg_busy_o  = (state_q == PENDING);
    assign dbg_done_o  = done_q;
    assign dbg_rdata_o = rdata_q;

    // Arbiter must never grant an empty port
    gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dbg_gnt_i |-> (state_q == PENDING) || dbg_req_i);

endmodule

//--- hw/csr_interface.sv
`timescale 1ns/1ps

// Commit stage to CSR command decode
module csr_interface
    import drac_pkg::*;
    import csr_pkg::*;
(
    input  logic                     commit_valid_i,       // Instruction present at commit
    input  instr_type_t              commit_instr_type_i,
    input  logic [4:0]               commit_rs1_i,         // rs1 index or zimm
    input  logic [XLEN-1:0]          commit_result_i,      // rs1 value for register forms
    input  logic [CSR_ADDR_SIZE-1:0] commit_csr_addr_i,    // funct12 for system ops
    input  logic [PC_WIDTH-1:0]      commit_pc_i,
    input  logic                     commit_xcpt_i,        // Exception raised upstream
    input  logic [CAUSE_WIDTH-1:0]   commit_xcpt_cause_i,
    output logic                     cmt_ena_o,            // CSR access requested
    output csr_cmd_t                 cmt_cmd_o,
    output logic [CSR_ADDR_SIZE-1:0] cmt_addr_o,
    output logic [XLEN-1:0]          cmt_wdata_o,
    output logic                     cmt_xcpt_o,
    output logic [CAUSE_WIDTH-1:0]   cmt_cause_o,
    output logic [PC_WIDTH-1:0]      cmt_pc_o,
    output logic                     cmt_retire_o          // Counts toward minstret
);

    logic            csr_ena_int;
    csr_cmd_t        csr_cmd_int;
    logic [XLEN-1:0] csr_wdata_int;
    logic [XLEN-1:0] zimm;
    logic            rs1_zero;
    logic            imm_form;

    assign zimm     = {{(XLEN-5){1'b0}}, commit_rs1_i};  // Zero-extended uimm
    assign rs1_zero = (commit_rs1_i == 5'd0);
    assign imm_form = (commit_instr_type_i == CSRRWI) || (commit_instr_type_i == CSRRSI)
                   || (commit_instr_type_i == CSRRCI);

    always_comb begin
        csr_cmd_int   = CSR_CMD_NOPE;
        csr_wdata_int = '0;
        csr_ena_int   = 1'b0;
        if (commit_valid_i) begin
            case (commit_instr_type_i)
                CSRRW, CSRRWI: begin
                    csr_cmd_int   = CSR_CMD_WRITE;   // Always writes even with x0
                    csr_wdata_int = imm_form ? zimm : commit_result_i;
                    csr_ena_int   = 1'b1;
                end
                CSRRS, CSRRSI: begin
                    // x0 or zero uimm means no write side effect
                    csr_cmd_int   = rs1_zero ? CSR_CMD_READ : CSR_CMD_SET;
                    csr_wdata_int = imm_form ? zimm : commit_result_i;
                    csr_ena_int   = 1'b1;
                end
                CSRRC, CSRRCI: begin
                    csr_cmd_int   = rs1_zero ? CSR_CMD_READ : CSR_CMD_CLEAR;
                    csr_wdata_int = imm_form ? zimm : commit_result_i;
                    csr_ena_int   = 1'b1;
                end
                ECALL, EBREAK, MRET, WFI, SFENCE_VMA: begin
                    csr_cmd_int   = CSR_CMD_SYS;     // CSR file sorts them by funct12
                    csr_wdata_int = '0;
                    csr_ena_int   = 1'b1;
                end
                default: begin
                    csr_ena_int = 1'b0;              // ALU, LOAD, STORE
                end
            endcase
        end
        // Upstream fault only rides on a valid commit
        if (commit_xcpt_i) begin
            assert (commit_valid_i)
                else $error("csr_interface: exception flagged without a valid commit");
        end
    end

    assign cmt_ena_o    = csr_ena_int;
    assign cmt_cmd_o    = csr_cmd_int;
    assign cmt_addr_o   = csr_ena_int ? commit_csr_addr_i : {CSR_ADDR_SIZE{1'b0}};
    assign cmt_wdata_o  = csr_wdata_int;

    // Trap info passes straight on
    assign cmt_xcpt_o   = commit_xcpt_i;
    assign cmt_cause_o  = commit_xcpt_cause_i;
    assign cmt_pc_o     = commit_pc_i;
    assign cmt_retire_o = commit_valid_i && !commit_xcpt_i;

endmodule

//--- hw/csr_pkg.sv
package csr_pkg;
    import drac_pkg::*;

    // Command on the CSR file bus
    typedef enum logic [2:0] {
        CSR_CMD_NOPE,
        CSR_CMD_WRITE,
        CSR_CMD_SET,
        CSR_CMD_CLEAR,
        CSR_CMD_READ,   // csrrs/csrrc with rs1 = x0
        CSR_CMD_SYS     // funct12 travels on the address bus
    } csr_cmd_t;

    // Machine CSR addresses
    localparam logic [CSR_ADDR_SIZE-1:0] ADDR_MSTATUS  = 12'h300;
    localparam logic [CSR_ADDR_SIZE-1:0] ADDR_MTVEC    = 12'h305;
    localparam logic [CSR_ADDR_SIZE-1:0] ADDR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_SIZE-1:0] ADDR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_SIZE-1:0] ADDR_MCAUSE   = 12'h342;
    localparam logic [CSR_ADDR_SIZE-1:0] ADDR_MINSTRET = 12'hB02;

    // System function codes, same as funct12 of the encoding
    localparam logic [CSR_ADDR_SIZE-1:0] FN_ECALL  = 12'h000;
    localparam logic [CSR_ADDR_SIZE-1:0] FN_EBREAK = 12'h001;
    localparam logic [CSR_ADDR_SIZE-1:0] FN_MRET   = 12'h302;
    localparam logic [CSR_ADDR_SIZE-1:0] FN_WFI    = 12'h105;

    // mstatus fields kept by this core
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;

    // Writable bits
    localparam logic [XLEN-1:0] MSTATUS_WMASK =
        (XLEN'(1) << MSTATUS_MIE) | (XLEN'(1) << MSTATUS_MPIE);
    localparam logic [XLEN-1:0] MTVEC_ALIGN_MASK = ~XLEN'(3); // Direct mode, 4-byte base

endpackage

//--- hw/csr_regfile.sv
`timescale 1ns/1ps

// Machine-mode CSR set
module csr_regfile
    import drac_pkg::*;
    import csr_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  csr_cmd_t                 rf_cmd_i,
    input  logic [CSR_ADDR_SIZE-1:0] rf_addr_i,   // CSR address or funct12
    input  logic [XLEN-1:0]          rf_wdata_i,
    input  logic                     rf_xcpt_i,
    input  logic [CAUSE_WIDTH-1:0]   rf_cause_i,
    input  logic [PC_WIDTH-1:0]      rf_pc_i,
    input  logic                     rf_retire_i,
    output logic [XLEN-1:0]          csr_rdata_o,  // Old value
    output logic                     csr_trap_o,   // Redirect fetch
    output logic [PC_WIDTH-1:0]      csr_evec_o
);

    logic [XLEN-1:0]        mstatus_q;
    logic [XLEN-1:0]        mtvec_q;
    logic [XLEN-1:0]        mscratch_q;
    logic [XLEN-1:0]        mepc_q;
    logic [XLEN-1:0]        mcause_q;
    logic [XLEN-1:0]        minstret_q;
    logic [XLEN-1:0]        rdata;
    logic [XLEN-1:0]        wval;
    logic                   wr_en;
    logic                   sys_ecall;
    logic                   sys_ebreak;
    logic                   sys_mret;
    logic                   trap_take;
    logic [CAUSE_WIDTH-1:0] trap_cause;

    always_comb begin
        case (rf_addr_i)
            ADDR_MSTATUS:  rdata = mstatus_q;
            ADDR_MTVEC:    rdata = mtvec_q;
            ADDR_MSCRATCH: rdata = mscratch_q;
            ADDR_MEPC:     rdata = mepc_q;
            ADDR_MCAUSE:   rdata = mcause_q;
            ADDR_MINSTRET: rdata = minstret_q;
            default:       rdata = '0;  // Unknown CSRs read as zero
        endcase
    end

    // Read-modify-write value squashed by a trap
    always_comb begin
        wr_en = !rf_xcpt_i;
        case (rf_cmd_i)
            CSR_CMD_WRITE: wval = rf_wdata_i;
            CSR_CMD_SET:   wval = rdata | rf_wdata_i;
            CSR_CMD_CLEAR: wval = rdata & ~rf_wdata_i;
            default: begin
                wval  = rdata;
                wr_en = 1'b0;       // READ, SYS, NOPE
            end
        endcase
    end

    always_comb begin
        sys_ecall  = 1'b0;
        sys_ebreak = 1'b0;
        sys_mret   = 1'b0;
        if ((rf_cmd_i == CSR_CMD_SYS) && !rf_xcpt_i) begin
            case (rf_addr_i)
                FN_ECALL:  sys_ecall  = 1'b1;
                FN_EBREAK: sys_ebreak = 1'b1;
                FN_MRET:   sys_mret   = 1'b1;
                FN_WFI:    ;            // No interrupts to wait for
                default:   ;            // SFENCE_VMA
            endcase
        end
    end

    assign trap_take  = rf_xcpt_i || sys_ecall || sys_ebreak;
    assign trap_cause = rf_xcpt_i ? rf_cause_i :
                        sys_ecall ? CAUSE_ECALL_M : CAUSE_BREAKPOINT;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mstatus_q  <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            minstret_q <= '0;
        end else begin
            if (wr_en) begin
                case (rf_addr_i)
                    ADDR_MSTATUS:  mstatus_q  <= wval & MSTATUS_WMASK; // MIE/MPIE only
                    ADDR_MTVEC:    mtvec_q    <= wval & MTVEC_ALIGN_MASK;
                    ADDR_MSCRATCH: mscratch_q <= wval;
                    ADDR_MEPC:     mepc_q     <= wval;
                    ADDR_MCAUSE:   mcause_q   <= wval;
                    default:       ;
                endcase
            end
            if (trap_take) begin
                mepc_q                  <= rf_pc_i;
                mcause_q                <= trap_cause;
                mstatus_q[MSTATUS_MPIE] <= mstatus_q[MSTATUS_MIE]; // Stack MIE
                mstatus_q[MSTATUS_MIE]  <= 1'b0;
            end else if (sys_mret) begin
                mstatus_q[MSTATUS_MIE]  <= mstatus_q[MSTATUS_MPIE];
                mstatus_q[MSTATUS_MPIE] <= 1'b1;
            end
            // Explicit write beats the retire count
            if (wr_en && (rf_addr_i == ADDR_MINSTRET)) begin
                minstret_q <= wval;
            end else if (rf_retire_i) begin
                minstret_q <= minstret_q + 1'b1;
            end
        end
    end

    assign csr_rdata_o = rdata;
    assign csr_trap_o  = trap_take || sys_mret;
    assign csr_evec_o  = trap_take ? mtvec_q :
                         sys_mret  ? mepc_q  : '0;

    // Faulting op never retires
    xcpt_no_retire: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(rf_retire_i && rf_xcpt_i));

    // System ops only come from a committing instruction
    sys_from_commit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rf_cmd_i == CSR_CMD_SYS) |-> (rf_retire_i || rf_xcpt_i));

endmodule

//--- hw/csr_top.sv
`timescale 1ns/1ps

module csr_top
    import drac_pkg::*;
    import csr_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     commit_valid_i,
    input  instr_type_t              commit_instr_type_i,
    input  logic [4:0]               commit_rs1_i,
    input  logic [XLEN-1:0]          commit_result_i,
    input  logic [CSR_ADDR_SIZE-1:0] commit_csr_addr_i,
    input  logic [PC_WIDTH-1:0]      commit_pc_i,
    input  logic                     commit_xcpt_i,
    input  logic [CAUSE_WIDTH-1:0]   commit_xcpt_cause_i,
    input  logic                     dbg_req_i,
    input  csr_cmd_t                 dbg_cmd_i,
    input  logic [CSR_ADDR_SIZE-1:0] dbg_addr_i,
    input  logic [XLEN-1:0]          dbg_wdata_i,
    output logic                     dbg_busy_o,
    output logic                     dbg_done_o,
    output logic [XLEN-1:0]          dbg_rdata_o,
    output logic [XLEN-1:0]          csr_rdata_o,
    output logic                     csr_trap_o,
    output logic [PC_WIDTH-1:0]      csr_evec_o
);

    // Commit peer to arbiter
    logic                     cmt_ena, cmt_xcpt, cmt_retire;
    csr_cmd_t                 cmt_cmd;
    logic [CSR_ADDR_SIZE-1:0] cmt_addr;
    logic [XLEN-1:0]          cmt_wdata;
    logic [CAUSE_WIDTH-1:0]   cmt_cause;
    logic [PC_WIDTH-1:0]      cmt_pc;
    // Debug peer to arbiter
    logic                     dbg_pend, dbg_gnt;
    csr_cmd_t                 dbg_cmd;
    logic [CSR_ADDR_SIZE-1:0] dbg_addr;
    logic [XLEN-1:0]          dbg_wdata;
    // Shared CSR file bus
    csr_cmd_t                 rf_cmd;
    logic [CSR_ADDR_SIZE-1:0] rf_addr;
    logic [XLEN-1:0]          rf_wdata;
    logic                     rf_xcpt, rf_retire;
    logic [CAUSE_WIDTH-1:0]   rf_cause;
    logic [PC_WIDTH-1:0]      rf_pc;

    csr_interface u_csr_interface (
        .commit_valid_i      (commit_valid_i),
        .commit_instr_type_i (commit_instr_type_i),
        .commit_rs1_i        (commit_rs1_i),
        .commit_result_i     (commit_result_i),
        .commit_csr_addr_i   (commit_csr_addr_i),
        .commit_pc_i         (commit_pc_i),
        .commit_xcpt_i       (commit_xcpt_i),
        .commit_xcpt_cause_i (commit_xcpt_cause_i),
        .cmt_ena_o           (cmt_ena),
        .cmt_cmd_o           (cmt_cmd),
        .cmt_addr_o          (cmt_addr),
        .cmt_wdata_o         (cmt_wdata),
        .cmt_xcpt_o          (cmt_xcpt),
        .cmt_cause_o         (cmt_cause),
        .cmt_pc_o            (cmt_pc),
        .cmt_retire_o        (cmt_retire)
    );

    csr_debug_port u_csr_debug_port (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .dbg_req_i   (dbg_req_i),
        .dbg_cmd_i   (dbg_cmd_i),
        .dbg_addr_i  (dbg_addr_i),
        .dbg_wdata_i (dbg_wdata_i),
        .dbg_gnt_i   (dbg_gnt),
        .rf_rdata_i  (csr_rdata_o),  // Same read bus as commit
        .dbg_pend_o  (dbg_pend),
        .dbg_cmd_o   (dbg_cmd),
        .dbg_addr_o  (dbg_addr),
        .dbg_wdata_o (dbg_wdata),
        .dbg_busy_o  (dbg_busy_o),
        .dbg_done_o  (dbg_done_o),
        .dbg_rdata_o (dbg_rdata_o)
    );

    csr_access_arbiter u_csr_access_arbiter (
        .cmt_ena_i    (cmt_ena),
        .cmt_cmd_i    (cmt_cmd),
        .cmt_addr_i   (cmt_addr),
        .cmt_wdata_i  (cmt_wdata),
        .cmt_xcpt_i   (cmt_xcpt),
        .cmt_cause_i  (cmt_cause),
        .cmt_pc_i     (cmt_pc),
        .cmt_retire_i (cmt_retire),
        .dbg_pend_i   (dbg_pend),
        .dbg_cmd_i    (dbg_cmd),
        .dbg_addr_i   (dbg_addr),
        .dbg_wdata_i  (dbg_wdata),
        .rf_cmd_o     (rf_cmd),
        .rf_addr_o    (rf_addr),
        .rf_wdata_o   (rf_wdata),
        .rf_xcpt_o    (rf_xcpt),
        .rf_cause_o   (rf_cause),
        .rf_pc_o      (rf_pc),
        .rf_retire_o  (rf_retire),
        .dbg_gnt_o    (dbg_gnt)
    );

    csr_regfile u_csr_regfile (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rf_cmd_i    (rf_cmd),
        .rf_addr_i   (rf_addr),
        .rf_wdata_i  (rf_wdata),
        .rf_xcpt_i   (rf_xcpt),
        .rf_cause_i  (rf_cause),
        .rf_pc_i     (rf_pc),
        .rf_retire_i (rf_retire),
        .csr_rdata_o (csr_rdata_o),
        .csr_trap_o  (csr_trap_o),
        .csr_evec_o  (csr_evec_o)
    );

endmodule

//--- hw/drac_pkg.sv
package drac_pkg;

    // Datapath widths
    localparam int XLEN          = 64;
    localparam int PC_WIDTH      = 64;
    localparam int CSR_ADDR_SIZE = 12;  // Zicsr address space
    localparam int CAUSE_WIDTH   = 64;  // Full mcause width

    // Kind of the instruction sitting at commit
    typedef enum logic [3:0] {
        ALU,         // Integer op, no CSR effect
        LOAD,
        STORE,
        CSRRW,       // Register forms take rs1 value from result
        CSRRS,
        CSRRC,
        CSRRWI,      // Immediate forms carry zimm in rs1 field
        CSRRSI,
        CSRRCI,
        ECALL,
        EBREAK,
        MRET,
        WFI,         // Hint only here
        SFENCE_VMA   // Accepted, no VM behind it
    } instr_type_t;

    // Synchronous exception codes written to mcause
    localparam logic [CAUSE_WIDTH-1:0] CAUSE_BREAKPOINT = CAUSE_WIDTH'(3);
    localparam logic [CAUSE_WIDTH-1:0] CAUSE_ECALL_M    = CAUSE_WIDTH'(11); // ECALL from M-mode

endpackage

//--- run.sh
#!/usr/bin/env bash
# Build and run the CSR testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module csr_tb -f src.f -o csr_sim

./obj_dir/csr_sim | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

//--- src.f
hw/drac_pkg.sv
hw/csr_pkg.sv
hw/csr_interface.sv
hw/csr_debug_port.sv
hw/csr_access_arbiter.sv
hw/csr_regfile.sv
hw/csr_top.sv
verification/csr_clk_gen.sv
verification/csr_tb.sv

//--- verification/csr_clk_gen.sv
`timescale 1ns/1ps

// Clock and reset source for the CSR testbench
module csr_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;  // 4 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        rst_n_o <= 1'b1;            // Released on an edge
    end

endmodule

//--- verification/csr_tb.sv
`timescale 1ns/1ps

module csr_tb
    import drac_pkg::*;
    import csr_pkg::*;
;

    localparam logic [11:0] SFENCE_FN = 12'h120;  // funct12 of sfence.vma with rs2 = x0

    logic clk_i, rst_n_i;
    logic commit_valid_i, commit_xcpt_i, dbg_req_i;
    instr_type_t commit_instr_type_i;
    logic [4:0] commit_rs1_i;
    logic [63:0] commit_result_i, commit_pc_i, commit_xcpt_cause_i, dbg_wdata_i;
    logic [11:0] commit_csr_addr_i, dbg_addr_i;
    csr_cmd_t dbg_cmd_i;
    logic dbg_busy_o, dbg_done_o, csr_trap_o;
    logic [63:0] dbg_rdata_o, csr_rdata_o, csr_evec_o;

    // Reference model state
    logic [63:0] mstatus_m = '0, mtvec_m = '0, mscratch_m = '0;
    logic [63:0] mepc_m = '0, mcause_m = '0, minstret_m = '0;
    logic dbg_pend_m = 1'b0;         // Request held in the debug unit
    logic done_m = 1'b0;             // Done pulse due this cycle
    logic [63:0] dbg_rdata_m = '0;
    csr_cmd_t dbg_cmd_m = CSR_CMD_NOPE;
    logic [11:0] dbg_addr_m = '0;
    logic [63:0] dbg_wdata_m = '0;
    logic [31:0] rng_state = 32'hc293f9bb;
    int cycle_cnt = 0;

    csr_clk_gen u_clk_gen (.clk_o(clk_i), .rst_n_o(rst_n_i));

    csr_top UUT (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [63:0] rand64();
        return {rand32(), rand32()};
    endfunction

    function automatic logic [11:0] csr_addr_at(input int idx);
        case (idx)
            0: return 12'h300;       // mstatus
            1: return 12'h305;       // mtvec
            2: return 12'h340;       // mscratch
            3: return 12'h341;       // mepc
            4: return 12'h342;       // mcause
            default: return 12'hB02; // minstret
        endcase
    endfunction

    function automatic csr_cmd_t pick_dbg_cmd(input logic [1:0] sel);
        case (sel)
            2'd0: return CSR_CMD_WRITE;
            2'd1: return CSR_CMD_SET;
            2'd2: return CSR_CMD_CLEAR;
            default: return CSR_CMD_READ;
        endcase
    endfunction

    function automatic logic [63:0] read_model(input logic [11:0] addr);
        case (addr)
            12'h300: return mstatus_m;
            12'h305: return mtvec_m;
            12'h340: return mscratch_m;
            12'h341: return mepc_m;
            12'h342: return mcause_m;
            12'hB02: return minstret_m;
            default: return 64'd0;   // Unknown CSR reads zero
        endcase
    endfunction

    function automatic void write_model(input logic [11:0] addr, input logic [63:0] val);
        case (addr)
            12'h300: mstatus_m = val & 64'h88;      // Only MIE and MPIE stick
            12'h305: mtvec_m = {val[63:2], 2'b00};  // 4-byte aligned base
            12'h340: mscratch_m = val;
            12'h341: mepc_m = val;
            12'h342: mcause_m = val;
            12'hB02: minstret_m = val;
            default: ;
        endcase
    endfunction

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            fail_stop($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // One random commit slot driven right after the edge
    task automatic drive_commit(input logic force_valid);
        logic [31:0] r;
        logic [11:0] addr;
        logic v;
        instr_type_t kind;
        r = rand32();
        addr = csr_addr_at(int'(rand32() % 32'd6));
        case (r[3:0])
            4'd0: kind = ALU;
            4'd1: kind = LOAD;
            4'd2: kind = STORE;
            4'd3, 4'd4: kind = CSRRW;
            4'd5, 4'd6: kind = CSRRS;
            4'd7, 4'd8: kind = CSRRC;
            4'd9: kind = CSRRWI;
            4'd10: kind = CSRRSI;
            4'd11: kind = CSRRCI;
            4'd12: kind = ECALL;
            4'd13: kind = EBREAK;
            4'd14: kind = MRET;
            default: kind = r[21] ? WFI : SFENCE_VMA;
        endcase
        case (kind)
            ECALL: addr = 12'h000;
            EBREAK: addr = 12'h001;
            MRET: addr = 12'h302;
            WFI: addr = 12'h105;
            SFENCE_VMA: addr = SFENCE_FN;
            default: ;
        endcase
        v = force_valid || (r[5:4] != 2'b00);
        commit_valid_i <= v;
        commit_instr_type_i <= kind;
        commit_rs1_i <= (r[7:6] == 2'b00) ? 5'd0 : r[12:8];  // Bias toward x0 reads
        commit_result_i <= rand64();
        commit_csr_addr_i <= addr;
        commit_pc_i <= rand64() & ~64'h3;
        commit_xcpt_i <= v && (r[16:13] == 4'd0);             // Rare upstream fault
        commit_xcpt_cause_i <= 64'(r[20:17]);
    endtask

    task automatic drive_idle();
        commit_valid_i <= 1'b0;
        commit_xcpt_i <= 1'b0;
    endtask

    // Falling edge sample then compare and advance the model
    task automatic check_cycle();
        logic [11:0] sel_addr;
        logic [63:0] old_val, op_data, new_val, exp_evec;
        logic exp_trap, is_csr, is_sys, is_imm, inc_ok, take, active, grant;
        csr_cmd_t op;
        instr_type_t kind;
        @(negedge clk_i);
        cycle_cnt++;
        kind = commit_instr_type_i;
        exp_trap = 1'b0;
        exp_evec = 64'd0;
        inc_ok = 1'b1;
        grant = 1'b0;
        op = CSR_CMD_NOPE;
        op_data = 64'd0;
        sel_addr = 12'h000;
        is_imm = kind inside {CSRRWI, CSRRSI, CSRRCI};
        is_csr = is_imm || (kind inside {CSRRW, CSRRS, CSRRC});
        is_sys = kind inside {ECALL, EBREAK, MRET, WFI, SFENCE_VMA};
        take = dbg_req_i && !dbg_pend_m;
        active = take || dbg_pend_m;
        if (commit_valid_i) begin
            sel_addr = (is_csr || is_sys) ? commit_csr_addr_i : 12'h000;
            op_data = is_imm ? {59'd0, commit_rs1_i} : commit_result_i;
            case (kind)
                CSRRW, CSRRWI: op = CSR_CMD_WRITE;
                CSRRS, CSRRSI: op = (commit_rs1_i == 5'd0) ? CSR_CMD_READ : CSR_CMD_SET;
                CSRRC, CSRRCI: op = (commit_rs1_i == 5'd0) ? CSR_CMD_READ : CSR_CMD_CLEAR;
                default: ;
            endcase
        end else if (active) begin
            grant = 1'b1;            // Free bus lets debug go now
            sel_addr = take ? dbg_addr_i : dbg_addr_m;
            op = take ? dbg_cmd_i : dbg_cmd_m;
            op_data = take ? dbg_wdata_i : dbg_wdata_m;
        end
        old_val = read_model(sel_addr);
        case (op)
            CSR_CMD_WRITE: new_val = op_data;
            CSR_CMD_SET: new_val = old_val | op_data;
            CSR_CMD_CLEAR: new_val = old_val & ~op_data;
            default: new_val = old_val;
        endcase
        if (commit_valid_i && (commit_xcpt_i || kind == ECALL || kind == EBREAK)) begin
            exp_trap = 1'b1;
            exp_evec = mtvec_m;
        end else if (commit_valid_i && kind == MRET) begin
            exp_trap = 1'b1;
            exp_evec = mepc_m;
        end
        check_val("csr_rdata_o", csr_rdata_o, old_val);
        check_val("csr_trap_o", 64'(csr_trap_o), 64'(exp_trap));
        check_val("csr_evec_o", csr_evec_o, exp_evec);
        check_val("dbg_busy_o", 64'(dbg_busy_o), 64'(dbg_pend_m));
        check_val("dbg_done_o", 64'(dbg_done_o), 64'(done_m));
        if (done_m) check_val("dbg_rdata_o", dbg_rdata_o, dbg_rdata_m);
        if (commit_valid_i && commit_xcpt_i) begin
            mepc_m = commit_pc_i;    // Faulting op neither writes nor retires
            mcause_m = commit_xcpt_cause_i;
            mstatus_m[7] = mstatus_m[3];
            mstatus_m[3] = 1'b0;
        end else begin
            if (op inside {CSR_CMD_WRITE, CSR_CMD_SET, CSR_CMD_CLEAR}) begin
                write_model(sel_addr, new_val);
                if (sel_addr == 12'hB02) inc_ok = 1'b0;  // Write wins over count
            end
            if (commit_valid_i) begin
                if (kind == ECALL || kind == EBREAK) begin
                    mepc_m = commit_pc_i;
                    mcause_m = (kind == ECALL) ? 64'd11 : 64'd3;
                    mstatus_m[7] = mstatus_m[3];
                    mstatus_m[3] = 1'b0;
                end else if (kind == MRET) begin
                    mstatus_m[3] = mstatus_m[7];
                    mstatus_m[7] = 1'b1;
                end
                if (inc_ok) minstret_m = minstret_m + 64'd1;
            end
        end
        if (take) begin
            dbg_cmd_m = dbg_cmd_i;
            dbg_addr_m = dbg_addr_i;
            dbg_wdata_m = dbg_wdata_i;
        end
        if (grant) dbg_rdata_m = old_val;
        done_m = grant;
        dbg_pend_m = active && !grant;
    endtask

    // Reset values seen through csrrs x0
    task automatic read_all_csrs();
        for (int i = 0; i < 6; i++) begin
            @(posedge clk_i);
            commit_valid_i <= 1'b1;
            commit_instr_type_i <= CSRRS;
            commit_rs1_i <= 5'd0;
            commit_csr_addr_i <= csr_addr_at(i);
            commit_xcpt_i <= 1'b0;
            check_cycle();
        end
    endtask

    // Host access optionally stalled by commit traffic
    task automatic debug_transfer();
        int n_bp;
        int waited;
        logic seen_done;
        n_bp = int'(rand32() % 32'd6);
        @(posedge clk_i);
        dbg_req_i <= 1'b1;
        dbg_cmd_i <= pick_dbg_cmd(2'(rand32() % 4));
        dbg_addr_i <= csr_addr_at(int'(rand32() % 32'd6));
        dbg_wdata_i <= rand64();
        if (n_bp > 0) drive_commit(1'b1);
        else drive_idle();
        check_cycle();
        for (int i = 1; i < n_bp; i++) begin
            @(posedge clk_i);
            dbg_req_i <= rand32() % 2 == 0;   // Strobes while busy get dropped
            dbg_cmd_i <= pick_dbg_cmd(2'(rand32() % 4));
            dbg_addr_i <= csr_addr_at(int'(rand32() % 32'd6));
            dbg_wdata_i <= rand64();
            drive_commit(1'b1);
            check_cycle();
        end
        waited = 0;
        seen_done = 1'b0;
        while (!seen_done && waited < 100) begin
            @(posedge clk_i);
            dbg_req_i <= 1'b0;
            drive_idle();
            check_cycle();
            seen_done = dbg_done_o;
            waited++;
        end
        if (!seen_done) fail_stop("debug request did not finish within 100 idle commit cycles");
    endtask

    initial begin
        int wait_cnt;
        commit_valid_i <= 1'b0;
        commit_instr_type_i <= ALU;
        commit_rs1_i <= 5'd0;
        commit_result_i <= 64'd0;
        commit_csr_addr_i <= 12'h000;
        commit_pc_i <= 64'd0;
        commit_xcpt_i <= 1'b0;
        commit_xcpt_cause_i <= 64'd0;
        dbg_req_i <= 1'b0;
        dbg_cmd_i <= CSR_CMD_NOPE;
        dbg_addr_i <= 12'h000;
        dbg_wdata_i <= 64'd0;
        wait_cnt = 0;
        while (rst_n_i !== 1'b1 && wait_cnt < 20) begin
            @(posedge clk_i);
            wait_cnt++;
        end
        if (rst_n_i !== 1'b1) fail_stop("reset was never released");
        read_all_csrs();
        while (cycle_cnt < 2000) begin
            if ((rand32() & 32'h7) == 32'h0) begin
                debug_transfer();
            end else begin
                @(posedge clk_i);
                dbg_req_i <= 1'b0;
                drive_commit(1'b0);
                check_cycle();
            end
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule
